/* all.f */
design/i2cMasterPkg.sv
design/i2cRegisterBank.sv
design/i2cSequencer.sv
design/i2cBusPort.sv
design/i2cMaster.sv
verif/i2cTargetModel.sv
verif/i2cMasterTb.sv

/* Bender.yml */
package:
  name: i2c_master

sources:
  - design/i2cMasterPkg.sv
  - design/i2cRegisterBank.sv
  - design/i2cSequencer.sv
  - design/i2cBusPort.sv
  - design/i2cMaster.sv
  - target: test
    files:
      - verif/i2cTargetModel.sv
      - verif/i2cMasterTb.sv

/* verif/i2cMasterTb.sv */
// testbench for the I2C master; runs the DUT at a clock divisor of 4 against one behavioural target
module i2cMasterTb;
  timeunit 1ns;
  timeprecision 100ps;
  import i2cMasterPkg::*;

  localparam int clockDivisor = 4;                    // five clk cycles per bus step
  localparam int worstTicks   = 4 + 10 * 27 + 4 + 3;  // start, ten bytes with ack, restart, stop
  localparam int transfers    = 8;
  localparam int watchdogNs   = worstTicks * (clockDivisor + 1) * 20 * transfers + 20000;
  localparam busWordT shortWrite = 32'h0001_01a0;     // one address byte, one data byte, target 0x50

  logic    clk;
  logic    reset;
  logic    write;
  logic    read;
  busWordT address;
  busWordT writeData;
  busWordT readData;
  wire     scl;
  wire     sda;
  logic    withholdAck;
  logic    holdSdaLow;
  busWordT supplyWord;
  busWordT status;
  integer  seed       = 32'h2deafc7c;
  int      errorCount = 0;
  int      checkCount = 0;
  int      stopBase;
  int      bitsBase;

  pullup (scl);
  pullup (sda);

  i2cMaster #(.clockDivisor(clockDivisor)) dut_i (
    .clk, .reset, .address, .write, .writeData, .read, .readData, .scl, .sda
  );

  i2cTargetModel target_i (
    .scl, .sda, .withholdAck, .holdSdaLow, .supplyWord
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;                           // 50 MHz
  end

  initial begin
    #(watchdogNs);
    errorCount++;
    $display("timeout after %0d ns, the master never went idle", watchdogNs);
    $display("checks %0d errors %0d", checkCount, errorCount);
    $display("ERRORS FOUND");
    $finish;
  end

  //////////////////////////////////////////////////
  // host access and checks
  //////////////////////////////////////////////////
  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checkCount++;
    assert (actual === expected) else begin
      errorCount++;
      $display("error %0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic writeReg(input busWordT addr, input busWordT data);
    @(negedge clk);
    address   = addr;
    writeData = data;
    write     = 1'b1;
    @(negedge clk);
    write = 1'b0;
  endtask

  task automatic readReg(input busWordT addr, output busWordT data);
    @(negedge clk);
    address = addr;
    read    = 1'b1;
    @(negedge clk);
    read = 1'b0;
    data = readData;                                  // registered on the edge in between
  endtask

  task automatic waitIdle(output busWordT data);
    do readReg(configAddr, data); while (data[31]);   // busy sits in bit 31
  endtask

  // random transfer, checked byte for byte at the target
  task automatic runTransfer(input logic readNotWrite);
    transferConfigT cfg;
    busWordT        rnd;
    busWordT        regAddr;
    busWordT        wrWord;
    busWordT        word;
    busWordT        expRead;
    logic [7:0]     expBytes [0:9];
    int             expCount;
    int             rxBase;
    int             startBase;
    int             stopStart;
    int             ackBase;
    cfg.readNotWrite = readNotWrite;
    rnd              = $random(seed);
    cfg.deviceAddr   = rnd[6:0];
    rnd              = $random(seed);
    cfg.addrBytes    = rnd % 5;
    rnd              = $random(seed);
    cfg.dataBytes    = 1 + rnd % 4;
    regAddr          = $random(seed);
    wrWord           = $random(seed);
    supplyWord       = $random(seed);
    expBytes[0] = {cfg.deviceAddr, 1'b0};             // first device byte always writes
    expCount    = 1;
    for (int k = int'(cfg.addrBytes) - 1; k >= 0; k--) begin
      expBytes[expCount] = regAddr[8 * k +: 8];       // address goes msb first
      expCount           = expCount + 1;
    end
    if (readNotWrite) begin
      expBytes[expCount] = {cfg.deviceAddr, 1'b1};    // after the repeated start
      expCount           = expCount + 1;
    end else begin
      for (int k = 0; k < cfg.dataBytes; k++) begin
        expBytes[expCount] = wrWord[8 * k +: 8];      // data goes lsb first
        expCount           = expCount + 1;
      end
    end
    rxBase    = target_i.rxCount;
    startBase = target_i.startCount;
    stopStart = target_i.stopCount;
    ackBase   = target_i.ackCount;
    writeReg(addrRegAddr, regAddr);
    writeReg(wrDataAddr, wrWord);
    writeReg(configAddr, {8'h00, cfg});
    readReg(configAddr, word);
    checkValue("config", {8'h80, cfg}, word);         // busy set, error clear
    waitIdle(word);
    checkValue("error", 0, word[30]);
    checkValue("received byte count", expCount, target_i.rxCount - rxBase);
    for (int i = 0; i < expCount; i++) begin
      checkValue("received byte", expBytes[i], target_i.rxBytes[rxBase + i]);
    end
    checkValue("stop count", 1, target_i.stopCount - stopStart);
    if (readNotWrite) begin
      checkValue("start count", 2, target_i.startCount - startBase);
      expRead = '0;
      for (int k = 0; k < cfg.dataBytes; k++) begin
        expRead = (expRead << 8) | supplyWord[8 * k +: 8];  // first byte ends up highest
      end
      readReg(rdDataAddr, word);
      checkValue("readData", expRead, word);
      checkValue("master answer count", cfg.dataBytes, target_i.ackCount - ackBase);
      checkValue("master answers", (32'd1 << cfg.dataBytes) - 32'd2,
                 target_i.ackPattern & ((32'd1 << cfg.dataBytes) - 32'd1));
    end
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////
  initial begin
    reset       = 1'b1;
    write       = 1'b0;
    read        = 1'b0;
    address     = '0;
    writeData   = '0;
    withholdAck = 1'b0;
    holdSdaLow  = 1'b0;
    supplyWord  = '0;
    repeat (2) @(negedge clk);
    reset = 1'b0;

    checkValue("scl", 1, scl);                        // both lines released after reset
    checkValue("sda", 1, sda);
    checkValue("readData", 0, readData);
    readReg(configAddr, status);
    checkValue("busy and error", 0, status[31:30]);

    repeat (2) runTransfer(1'b0);
    repeat (2) runTransfer(1'b1);

    withholdAck = 1'b1;                               // device byte gets no ack
    stopBase    = target_i.stopCount;
    writeReg(configAddr, shortWrite);
    waitIdle(status);
    checkValue("error", 1, status[30]);
    checkValue("stop count", 1, target_i.stopCount - stopBase);
    withholdAck = 1'b0;
    writeReg(configAddr, shortWrite);                 // new transfer clears the error
    readReg(configAddr, status);
    checkValue("error", 0, status[30]);
    waitIdle(status);

    holdSdaLow = 1'b1;                                // bus looks taken at start
    bitsBase   = target_i.bitsSeen;
    writeReg(configAddr, shortWrite);
    waitIdle(status);
    checkValue("error", 1, status[30]);
    checkValue("scl rises", 1, target_i.bitsSeen - bitsBase);  // only the stop clocks scl
    holdSdaLow = 1'b0;

    readReg(addrRegAddr, status);                     // write-only and unmapped words read zero
    checkValue("readData", 0, status);
    readReg(wrDataAddr, status);
    checkValue("readData", 0, status);
    readReg(32'h0000_2004, status);
    checkValue("readData", 0, status);
    readReg(configAddr, status);
    checkValue("readData", {2'b01, 6'b0, shortWrite[23:0]}, status);
    @(negedge clk);
    checkValue("readData", 0, readData);              // cleared once read has dropped

    $display("checks %0d errors %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* verif/i2cTargetModel.sv */
// behavioural I2C target; answers any device address, sends at most four read bytes and needs pull-ups
module i2cTargetModel (
  inout  wire         scl,
  inout  wire         sda,
  input  logic        withholdAck,  // nack the first byte after every start
  input  logic        holdSdaLow,   // keeps sda pulled low so the bus looks busy
  input  logic [31:0] supplyWord    // read data, bits 7:0 go out first
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [7:0]  rxBytes [0:255];     // every byte the master sent, in bus order
  int          rxCount    = 0;
  int          startCount = 0;      // start and repeated start conditions
  int          stopCount  = 0;
  int          bitsSeen   = 0;      // every scl rise, with or without a start
  int          ackCount   = 0;      // answer slots on bytes this model sent
  logic [31:0] ackPattern = '0;     // master answers, newest in bit 0, high for an ack
  logic        active     = 1'b0;   // between a start and a stop
  logic        sending    = 1'b0;   // this model drives the data bits
  logic        reading    = 1'b0;   // device byte of this start asked for a read
  logic        masterAck  = 1'b0;
  logic        sdaPull    = 1'b0;
  logic [7:0]  shiftReg   = '0;
  logic [7:0]  txByte     = '0;
  int          bitCount   = 0;      // scl rises in the current byte, the ninth is the ack
  int          byteIndex  = 0;      // bytes since the last start
  int          txIndex    = 0;      // next byte of supplyWord
  logic        sclPrev    = 1'b1;
  logic        sdaPrev    = 1'b1;
  logic        sclNow;
  logic        sdaNow;

  assign sda = (sdaPull || holdSdaLow) ? 1'b0 : 1'bz;  // open drain like the master

  //////////////////////////////////////////////////
  // line watcher, one process for every edge
  //////////////////////////////////////////////////
  always @(scl or sda) begin
    sclNow = (scl === 1'b1);
    sdaNow = (sda === 1'b1);
    if (!sclPrev && sclNow) begin
      bitsSeen++;                                     // also counts clocks on a taken bus
    end
    if (sclPrev && sclNow && sdaPrev && !sdaNow && !holdSdaLow) begin
      startCount++;                                   // sda fell with scl high
      active    = 1'b1;
      reading   = 1'b0;
      sending   = 1'b0;
      bitCount  = 0;
      byteIndex = 0;
    end else if (sclPrev && sclNow && !sdaPrev && sdaNow) begin
      stopCount++;                                    // sda rose with scl high
      active  = 1'b0;
      sdaPull = 1'b0;
    end else if (active && !sclPrev && sclNow) begin
      bitCount++;
      if (bitCount <= 8 && !sending) begin
        shiftReg = {shiftReg[6:0], sdaNow};           // msb arrives first
      end
      if (bitCount == 9 && sending) begin
        masterAck  = !sdaNow;                         // low line is an ack
        ackPattern = {ackPattern[30:0], masterAck};
        ackCount++;
      end
    end else if (active && sclPrev && !sclNow) begin
      if (bitCount == 8) begin
        if (sending) begin
          sdaPull = 1'b0;                             // free the line for the master's answer
        end else begin
          rxBytes[rxCount] = shiftReg;
          rxCount++;
          if (byteIndex == 0) begin
            reading = shiftReg[0];                    // R/W bit of the device byte
          end
          sdaPull = !(withholdAck && byteIndex == 0);
        end
      end else if (bitCount == 9) begin
        bitCount = 0;
        byteIndex++;
        if (!sending && reading && byteIndex == 1) begin
          sending = 1'b1;                             // read device byte acked, data follows
          txIndex = 0;
        end else if (sending && !masterAck) begin
          sending = 1'b0;                             // nack ends the read, stop comes next
        end
        if (sending) begin
          txByte  = supplyWord[8 * (txIndex % 4) +: 8];
          txIndex++;
          sdaPull = !txByte[7];
        end else begin
          sdaPull = 1'b0;
        end
      end else if (sending && bitCount > 0) begin
        sdaPull = !txByte[7 - bitCount];              // next bit while scl is low
      end
    end
    sclPrev = sclNow;
    sdaPrev = sdaNow;
  end

endmodule

/* design/i2cMaster.sv */
// I2C master top; bit rate is clk / (3 * (clockDivisor + 1)) with scl high for one of three steps
module i2cMaster #(
  parameter int clockDivisor = 105
) (
  input  logic                  clk,
  input  logic                  reset,
  input  i2cMasterPkg::busWordT address,
  input  logic                  write,
  input  i2cMasterPkg::busWordT writeData,
  input  logic                  read,
  output i2cMasterPkg::busWordT readData,
  inout  wire                   scl,
  inout  wire                   sda
);
  import i2cMasterPkg::*;

  transferConfigT transferConfig;  // shared by the FSM and the frame builder
  busWordT        regAddress;
  busWordT        wrData;
  busWordT        readWord;
  busControlT     control;
  busSenseT       sense;
  logic           busy;
  logic           transferDone;
  logic           busError;

  i2cRegisterBank registerBank_i (
    .clk, .reset, .write, .read, .address, .writeData,
    .transferDone, .busError, .readWord,
    .readData, .transferConfig, .regAddress, .wrData, .busy
  );

  i2cSequencer #(.clockDivisor(clockDivisor)) sequencer_i (
    .clk, .reset, .transferConfig, .busy, .sense,
    .control, .transferDone, .busError
  );

  i2cBusPort busPort_i (
    .clk, .reset, .control, .transferConfig, .regAddress, .wrData,
    .readWord, .sense, .scl, .sda
  );

endmodule

/* design/i2cBusPort.sv */
// open-drain pin stage; needs external pull-ups, and frame bits beyond the byte counts are ignored
module i2cBusPort (
  input  logic                         clk,
  input  logic                         reset,
  input  i2cMasterPkg::busControlT     control,
  input  i2cMasterPkg::transferConfigT transferConfig,
  input  i2cMasterPkg::busWordT        regAddress,
  input  i2cMasterPkg::busWordT        wrData,
  output i2cMasterPkg::busWordT        readWord,
  output i2cMasterPkg::busSenseT       sense,
  inout  wire                          scl,
  inout  wire                          sda
);
  import i2cMasterPkg::*;

  logic [frameBits-1:0] frame;      // msb is the bit on the line
  logic [2:0]           addrCount;  // address bytes placed after the device byte
  logic [5:0]           padShift;   // bits of unused address space
  busWordT              addrJust;   // used address bytes moved to the top
  busWordT              tailWord;   // second device byte on reads, swapped data on writes
  logic [63:0]          frameBody;  // everything after the first device byte
  busSenseT             senseMeta;  // first synchroniser stage

  ////////////////////////////////////////////////
  // frame assembly
  ////////////////////////////////////////////////
  assign addrCount = addrByteCount(transferConfig.addrBytes);
  assign padShift  = {3'(3'd4 - addrCount), 3'b000};   // 8 bits per missing byte
  assign addrJust  = regAddress << padShift;           // msb byte goes out first
  assign tailWord  = transferConfig.readNotWrite
                   ? {transferConfig.deviceAddr, 1'b1, 24'h0}
                   : {wrData[7:0], wrData[15:8], wrData[23:16], wrData[31:24]};
  // tail starts right after the last address byte
  assign frameBody = {addrJust, 32'h0} | ({32'h0, tailWord} << padShift);

  always_ff @(posedge clk) begin
    if (control.loadFrame) begin
      frame <= {transferConfig.deviceAddr, 1'b0, frameBody};  // first R/W is always low
    end else if (control.shiftOut) begin
      frame <= {frame[frameBits-2:0], 1'b0};
    end
  end

  ////////////////////////////////////////////////
  // read capture and pin synchroniser
  ////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset || control.loadFrame) begin
      readWord <= '0;                                // cleared at every start
    end else if (control.sampleIn) begin
      readWord <= {readWord[30:0], sense.sda};       // first byte ends up highest
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      senseMeta <= '1;                               // idle bus reads released
      sense     <= '1;
    end else begin
      senseMeta <= '{scl: scl, sda: sda};
      sense     <= senseMeta;
    end
  end

  // only ever pull low, the pull-ups provide the high level
  assign scl = control.sclLevel ? 1'bz : 1'b0;
  assign sda = (!control.sdaLevel || (control.sdaFromFrame && !frame[frameBits-1]))
             ? 1'b0 : 1'bz;

endmodule

/* design/i2cSequencer.sv */
// I2C phase sequencer; no clock stretching, and ack checks sample sda once per high scl phase
module i2cSequencer #(
  parameter int clockDivisor = 105
) (
  input  logic                         clk,
  input  logic                         reset,
  input  i2cMasterPkg::transferConfigT transferConfig,
  input  logic                         busy,
  input  i2cMasterPkg::busSenseT       sense,
  output i2cMasterPkg::busControlT     control,
  output logic                         transferDone,
  output logic                         busError
);
  import i2cMasterPkg::*;

  localparam int divWidth = (clockDivisor > 0) ? $clog2(clockDivisor + 1) : 1;

  typedef enum logic [3:0] {
    phIdle, phCheckBus, phStartHold, phStartLow, phSendBit, phAckIn, phRestart,
    phRecvBit, phAckOut, phStopLow, phStopRise, phStopHold, phError
  } phaseT;

  logic [divWidth-1:0] divCount;   // clk cycles since the last tick
  logic                tick;       // one clk cycle per bus step
  phaseT               phase;
  logic [1:0]          step;       // low, high, low-and-shift within a bit (restart uses four)
  logic [2:0]          bitIndex;   // counts 7 down to 0 and wraps back to 7
  logic [2:0]          addrLeft;   // address bytes still to send after the current byte
  byteCountT           dataLeft;   // data bytes still to move
  logic                restarted;  // repeated start already issued on a read
  logic                lineFault;  // bus busy at start or a missing ack on this tick

  ////////////////////////////////////////////////
  // tick divider
  ////////////////////////////////////////////////
  assign tick = (divCount == divWidth'(clockDivisor));  // every clockDivisor+1 cycles

  always_ff @(posedge clk) begin
    if (reset || tick) begin
      divCount <= '0;
    end else begin
      divCount <= divCount + 1'b1;
    end
  end

  // all faults are judged on the tick that ends a high scl step
  assign lineFault = ((phase == phCheckBus) && !(sense.scl && sense.sda))
                  || ((phase == phAckIn) && (step == 2'd1) && sense.sda)
                  || ((phase == phAckOut) && (step == 2'd1) && (dataLeft != 8'd0) && sense.sda);

  ////////////////////////////////////////////////
  // phase FSM
  ////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      phase        <= phIdle;
      step         <= 2'd0;
      bitIndex     <= 3'd0;
      addrLeft     <= 3'd0;
      dataLeft     <= '0;
      restarted    <= 1'b0;
      transferDone <= 1'b0;
      busError     <= 1'b0;
    end else begin
      transferDone <= 1'b0;
      busError     <= 1'b0;
      if (tick && lineFault) begin
        phase    <= phError;                         // finish the clock low, then stop
        busError <= 1'b1;
      end else if (tick) begin
        case (phase)
          phIdle:      if (busy) phase <= phCheckBus;
          phCheckBus:  phase <= phStartHold;          // both lines seen released
          phStartHold: begin
            phase     <= phStartLow;
            addrLeft  <= addrByteCount(transferConfig.addrBytes);
            dataLeft  <= transferConfig.dataBytes;
            restarted <= 1'b0;
          end
          phStartLow: begin
            phase    <= phSendBit;
            step     <= 2'd0;
            bitIndex <= 3'd7;
          end
          phSendBit, phRecvBit: begin
            step <= (step == 2'd2) ? 2'd0 : step + 2'd1;
            if (step == 2'd2) begin
              bitIndex <= bitIndex - 3'd1;
              if (bitIndex == 3'd0) begin
                phase <= (phase == phSendBit) ? phAckIn : phAckOut;
                if (phase == phRecvBit) begin
                  dataLeft <= dataLeft - 8'd1;       // zero left means this byte gets a nack
                end
              end
            end
          end
          phAckIn: begin
            step <= step + 2'd1;
            if (step == 2'd2) begin
              step <= 2'd0;
              if (addrLeft != 3'd0) begin
                addrLeft <= addrLeft - 3'd1;         // next register address byte
                phase    <= phSendBit;
              end else if (!transferConfig.readNotWrite) begin
                if (dataLeft != 8'd0) begin
                  dataLeft <= dataLeft - 8'd1;       // next write data byte
                  phase    <= phSendBit;
                end else begin
                  phase <= phStopLow;
                end
              end else if (!restarted) begin
                phase <= phRestart;                  // switch the bus direction to read
              end else begin
                phase <= phRecvBit;                  // second device byte acknowledged
              end
            end
          end
          phRestart: begin
            step <= step + 2'd1;
            if (step == 2'd3) begin
              phase     <= phSendBit;
              restarted <= 1'b1;
            end
          end
          phAckOut: begin
            step <= step + 2'd1;
            if (step == 2'd2) begin
              step  <= 2'd0;
              phase <= (dataLeft == 8'd0) ? phStopLow : phRecvBit;
            end
          end
          phStopLow:   phase <= phStopRise;
          phStopRise:  phase <= phStopHold;
          phStopHold: begin
            phase        <= phIdle;
            transferDone <= 1'b1;                    // lets the register bank drop busy
          end
          phError:     phase <= phStopLow;
          default:     phase <= phIdle;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////
  // line levels and strobes per phase
  ////////////////////////////////////////////////
  always_comb begin
    control = '{sclLevel: 1'b1, sdaLevel: 1'b1, default: 1'b0};  // both lines released
    case (phase)
      phStartHold: begin
        control.sdaLevel  = 1'b0;                    // sda falls while scl is high
        control.loadFrame = tick;
      end
      phStartLow, phStopLow: begin
        control.sclLevel = 1'b0;
        control.sdaLevel = 1'b0;
      end
      phSendBit: begin
        control.sclLevel     = (step == 2'd1);
        control.sdaFromFrame = 1'b1;                 // frame msb drives sda
        control.shiftOut     = tick && (step == 2'd2);
      end
      phAckIn:     control.sclLevel = (step == 2'd1);  // target pulls sda low to ack
      phRestart: begin
        control.sclLevel = (step == 2'd1) || (step == 2'd2);
        control.sdaLevel = (step < 2'd2);            // sda falls with scl high on step 2
      end
      phRecvBit: begin
        control.sclLevel = (step == 2'd1);
        control.sampleIn = tick && (step == 2'd1);
      end
      phAckOut: begin
        control.sclLevel = (step == 2'd1);
        control.sdaLevel = (dataLeft == 8'd0);       // nack after the last byte
      end
      phStopRise:  control.sdaLevel = 1'b0;          // sda rises on the next step for stop
      phError:     control.sclLevel = 1'b0;
      default:     control.sclLevel = 1'b1;
    endcase
  end

endmodule

/* design/i2cRegisterBank.sv */
// host register block; a config write during a transfer overwrites the config and is not queued
module i2cRegisterBank (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         write,
  input  logic                         read,
  input  i2cMasterPkg::busWordT        address,
  input  i2cMasterPkg::busWordT        writeData,
  input  logic                         transferDone,
  input  logic                         busError,
  input  i2cMasterPkg::busWordT        readWord,
  output i2cMasterPkg::busWordT        readData,
  output i2cMasterPkg::transferConfigT transferConfig,
  output i2cMasterPkg::busWordT        regAddress,
  output i2cMasterPkg::busWordT        wrData,
  output logic                         busy
);
  import i2cMasterPkg::*;

  logic error;        // sticky bus fault flag
  logic configWrite;  // host kicks off a transfer

  assign configWrite = write && (address == configAddr);

  ////////////////////////////////////////////////
  // writable registers
  ////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      transferConfig <= '0;                          // sequencer sees an empty config after reset
    end else if (configWrite) begin
      transferConfig <= writeData[23:0];             // upper host bits carry status only
    end
  end

  always_ff @(posedge clk) begin
    if (write && (address == addrRegAddr)) begin
      regAddress <= writeData;                       // low addrBytes bytes are used, msb first
    end
    if (write && (address == wrDataAddr)) begin
      wrData <= writeData;                           // sent least significant byte first
    end
  end

  ////////////////////////////////////////////////
  // status flags
  ////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      busy  <= 1'b0;
      error <= 1'b0;
    end else begin
      if (configWrite) begin
        busy <= 1'b1;                                // held until the stop has gone out
      end else if (transferDone) begin
        busy <= 1'b0;
      end
      if (configWrite) begin
        error <= 1'b0;                               // a fresh transfer starts clean
      end else if (busError) begin
        error <= 1'b1;                               // stays until the next config write
      end
    end
  end

  ////////////////////////////////////////////////
  // read-back
  ////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      readData <= '0;
    end else if (read) begin
      case (address)
        configAddr: readData <= {busy, error, 6'b0, transferConfig};  // status over config
        rdDataAddr: readData <= readWord;                             // last received bytes
        default:    readData <= '0;                  // address and write data are not readable
      endcase
    end else begin
      readData <= '0;                                // word is only valid after a read strobe
    end
  end

endmodule

/* design/i2cMasterPkg.sv */
// shared I2C master definitions; address counts above 4 are clamped to 4 and data counts are not checked
package i2cMasterPkg;

  ////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////
  localparam logic [31:0] configAddr  = 32'h2000;  // write starts a transfer, read returns status
  localparam logic [31:0] addrRegAddr = 32'h2008;  // target register address, write only
  localparam logic [31:0] wrDataAddr  = 32'h2010;  // write data, first byte in bits 7:0
  localparam logic [31:0] rdDataAddr  = 32'h2018;  // received bytes, first one lands highest

  localparam int frameBits = 72;  // device byte, four address bytes and four data bytes

  typedef logic [31:0] busWordT;   // host data word
  typedef logic [7:0]  byteCountT; // byte count as laid out in the config register

  // config register layout, bits 23:0 of the host word
  typedef struct packed {
    byteCountT  dataBytes;    // 1 to 4 bytes moved in the data phase
    byteCountT  addrBytes;    // 0 to 4 register address bytes after the device byte
    logic [6:0] deviceAddr;   // 7-bit target address
    logic       readNotWrite; // high selects a read with a repeated start
  } transferConfigT;

  // per-tick line levels and strobes from the sequencer to the bus port
  typedef struct packed {
    logic sclLevel;     // low pulls scl down, high releases it
    logic sdaLevel;     // low pulls sda down regardless of the frame
    logic sdaFromFrame; // lets the frame msb pull sda down
    logic loadFrame;    // single-cycle strobe that builds the frame
    logic shiftOut;     // single-cycle strobe that moves to the next frame bit
    logic sampleIn;     // single-cycle strobe that captures sda into the read word
  } busControlT;

  // synchronised pin levels
  typedef struct packed {
    logic scl;
    logic sda;
  } busSenseT;

  // number of address bytes actually sent for a given config field
  function automatic logic [2:0] addrByteCount(byteCountT requested);
    return (requested > 8'd4) ? 3'd4 : requested[2:0];
  endfunction

endpackage
